/* common/backend_pkg.sv */
package backend_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int ecode_w    = 7;
    localparam int wb_sel_w   = 9;
    localparam int pd_type_w  = 2;
    localparam int bht_idx_w  = 4;    // 16 entries

    // Lane B write source bits, one-hot
    localparam int wb_sel_mul_lo = 1;
    localparam int wb_sel_mul_hi = 2;

    typedef logic [xlen-1:0]       word_t;     // Data or PC
    typedef logic [2*xlen-1:0]     dword_t;    // Multiplier partial product
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [ecode_w-1:0]    ecode_t;    // Zero means no exception
    typedef logic [wb_sel_w-1:0]   wb_sel_t;
    typedef logic [pd_type_w-1:0]  pd_type_t;  // Zero means not a branch
    typedef logic [bht_idx_w-1:0]  bht_idx_t;

    typedef enum logic [1:0] {
        run,
        stall_dc,
        stall_ex
    } hazard_state_t;

endpackage

/* src/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
    input  logic clk,
    input  logic arst_n,
    input  logic dcache_miss,
    input  logic div_busy,
    output logic stall_dcache,
    output logic stall_ex,
    output logic stall_dcache_buf,
    output logic stall_ex_buf
);
    import backend_pkg::*;

    hazard_state_t state_q;
    logic          ex_hidden_q;    // Divider stall masked by dcache stall

    assign stall_dcache     = dcache_miss;
    assign stall_ex         = div_busy;
    assign stall_dcache_buf = (state_q == backend_pkg::stall_dc);
    assign stall_ex_buf     = (state_q == backend_pkg::stall_ex) || ex_hidden_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= backend_pkg::run;
            ex_hidden_q <= 1'b0;
        end else begin
            if (dcache_miss) begin
                state_q <= backend_pkg::stall_dc;    // Dcache has priority
            end else if (div_busy) begin
                state_q <= backend_pkg::stall_ex;
            end else begin
                state_q <= backend_pkg::run;
            end
            ex_hidden_q <= dcache_miss && div_busy;
        end
    end

    a_dc_buf_follows: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(stall_dcache_buf) |-> $past(stall_dcache)
    );
    a_ex_buf_follows: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(stall_ex_buf) |-> $past(stall_ex)
    );

endmodule

/* src/mem_result_select.sv */
`timescale 1ns/100ps

module mem_result_select (
    input  backend_pkg::word_t   mem_alu_result_a,
    input  backend_pkg::word_t   mem_alu_result_b,
    input  backend_pkg::wb_sel_t mem_wb_sel_b,
    input  backend_pkg::dword_t  mem_mul_tmp1,
    input  backend_pkg::dword_t  mem_mul_tmp2,
    output backend_pkg::word_t   mem_rf_wdata_a,
    output backend_pkg::word_t   mem_rf_wdata_b
);
    import backend_pkg::*;

    dword_t mul_sum;    // Final multiplier product

    assign mul_sum        = mem_mul_tmp1 + mem_mul_tmp2;
    assign mem_rf_wdata_a = mem_alu_result_a;

    always_comb begin
        if (mem_wb_sel_b[wb_sel_mul_lo]) begin
            mem_rf_wdata_b = mul_sum[xlen-1:0];
        end else if (mem_wb_sel_b[wb_sel_mul_hi]) begin
            mem_rf_wdata_b = mul_sum[2*xlen-1:xlen];
        end else begin
            mem_rf_wdata_b = mem_alu_result_b;    // ALU and reserved bits
        end
    end

    // Decode upstream must never set two sources at once
    a_sel_onehot: assert final ($onehot0(mem_wb_sel_b));

endmodule

/* src/regfile.sv */
`timescale 1ns/100ps

module regfile (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   we_a,
    input  backend_pkg::reg_addr_t waddr_a,
    input  backend_pkg::word_t     wdata_a,
    input  logic                   we_b,
    input  backend_pkg::reg_addr_t waddr_b,
    input  backend_pkg::word_t     wdata_b,
    input  backend_pkg::reg_addr_t raddr_0,
    input  backend_pkg::reg_addr_t raddr_1,
    output backend_pkg::word_t     rdata_0,
    output backend_pkg::word_t     rdata_1
);
    import backend_pkg::*;

    localparam int n_regs = 1 << reg_addr_w;

    word_t regs_q [n_regs];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < n_regs; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (we_a && (waddr_a != '0)) begin
                regs_q[waddr_a] <= wdata_a;
            end
            // Lane B is younger, so its write lands last
            if (we_b && (waddr_b != '0)) begin
                regs_q[waddr_b] <= wdata_b;
            end
        end
    end

    assign rdata_0 = (raddr_0 == '0) ? '0 : regs_q[raddr_0];
    assign rdata_1 = (raddr_1 == '0) ? '0 : regs_q[raddr_1];

endmodule

/* src/branch_hist_table.sv */
`timescale 1ns/100ps

module branch_hist_table (
    input  logic                  clk,
    input  logic                  arst_n,
    input  backend_pkg::pd_type_t upd_pd_type,
    input  backend_pkg::word_t    upd_pc,
    input  backend_pkg::word_t    upd_target,
    input  logic                  upd_taken,
    input  backend_pkg::word_t    lookup_pc,
    output logic                  hit,
    output backend_pkg::pd_type_t hit_pd_type,
    output backend_pkg::word_t    hit_target,
    output logic                  hit_taken
);
    import backend_pkg::*;

    localparam int n_entries = 1 << bht_idx_w;

    logic     valid_q  [n_entries];
    logic     [xlen-1:bht_idx_w+2] tag_q [n_entries];    // PC above the index
    pd_type_t type_q   [n_entries];
    word_t    target_q [n_entries];
    logic     taken_q  [n_entries];
    bht_idx_t upd_idx;
    bht_idx_t lk_idx;

    assign upd_idx = upd_pc[bht_idx_w+1:2];
    assign lk_idx  = lookup_pc[bht_idx_w+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < n_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (|upd_pd_type) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (|upd_pd_type) begin
            tag_q[upd_idx]    <= upd_pc[xlen-1:bht_idx_w+2];
            type_q[upd_idx]   <= upd_pd_type;
            target_q[upd_idx] <= upd_target;
            taken_q[upd_idx]  <= upd_taken;
        end
    end

    assign hit         = valid_q[lk_idx] && (tag_q[lk_idx] == lookup_pc[xlen-1:bht_idx_w+2]);
    assign hit_pd_type = type_q[lk_idx];
    assign hit_target  = target_q[lk_idx];
    assign hit_taken   = taken_q[lk_idx];

endmodule

/* pipe_regs/ex_mem_wb_regs.sv */
`timescale 1ns/100ps

module ex_mem_wb_regs (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  stall_ex,
    input  logic                  stall_ex_buf,
    input  logic                  stall_dcache,
    input  logic                  stall_dcache_buf,
    input  logic                  wb_flush_csr,
    input  backend_pkg::ecode_t   mem_ecode_a,
    input  backend_pkg::ecode_t   mem_ecode_b,

    input  backend_pkg::word_t    ex_pc_a,
    input  backend_pkg::word_t    ex_pc_b,
    input  backend_pkg::word_t    ex_alu_result_a,
    input  backend_pkg::word_t    ex_alu_result_b,
    input  logic                  ex_rf_we_a,
    input  logic                  ex_rf_we_b,
    input  backend_pkg::reg_addr_t ex_rf_waddr_a,
    input  backend_pkg::reg_addr_t ex_rf_waddr_b,
    input  backend_pkg::wb_sel_t  ex_wb_sel_b,
    input  logic                  ex_br_a,          // Lane A mispredicted
    input  logic                  ex_br_b,
    input  backend_pkg::word_t    ex_pc_br_a,       // Corrected PC
    input  backend_pkg::word_t    ex_pc_br_b,
    input  logic                  ex_br_a_ori,      // Actual direction
    input  logic                  ex_br_b_ori,
    input  backend_pkg::word_t    ex_pc_br_a_ori,   // Actual target
    input  backend_pkg::word_t    ex_pc_br_b_ori,
    input  backend_pkg::pd_type_t ex_pd_type_a,
    input  backend_pkg::pd_type_t ex_pd_type_b,
    input  backend_pkg::dword_t   ex_mul_tmp1,
    input  backend_pkg::dword_t   ex_mul_tmp2,

    output backend_pkg::word_t    mem_alu_result_a,
    output backend_pkg::word_t    mem_alu_result_b,
    output backend_pkg::wb_sel_t  mem_wb_sel_b,
    output backend_pkg::dword_t   mem_mul_tmp1,
    output backend_pkg::dword_t   mem_mul_tmp2,
    input  backend_pkg::word_t    mem_rf_wdata_a,
    input  backend_pkg::word_t    mem_rf_wdata_b,

    output logic                  mem_br,
    output backend_pkg::word_t    mem_pc_br,

    output backend_pkg::pd_type_t mem_pd_type,
    output backend_pkg::word_t    mem_pc_of_br,
    output backend_pkg::word_t    mem_br_target,
    output logic                  mem_br_jump,

    output logic                  wb_rf_we_a,
    output logic                  wb_rf_we_b,
    output backend_pkg::reg_addr_t wb_rf_waddr_a,
    output backend_pkg::reg_addr_t wb_rf_waddr_b,
    output backend_pkg::word_t    wb_rf_wdata_a,
    output backend_pkg::word_t    wb_rf_wdata_b
);
    import backend_pkg::*;

    logic      advance;
    logic      br_ok;             // Branch effects allowed this cycle
    logic      flush_csr_buf;
    logic      mem_rf_we_a;
    logic      mem_rf_we_b_ori;   // Before lane A squash
    logic      mem_rf_we_b;
    logic      mem_br_a;
    logic      mem_br_b;
    pd_type_t  mem_pd_type_a;
    pd_type_t  mem_pd_type_b;
    word_t     mem_pc_a;
    word_t     mem_pc_b;
    word_t     mem_pc_br_a;
    word_t     mem_pc_br_b;
    logic      mem_br_a_ori;
    logic      mem_br_b_ori;
    word_t     mem_pc_br_a_ori;
    word_t     mem_pc_br_b_ori;
    reg_addr_t mem_rf_waddr_a;
    reg_addr_t mem_rf_waddr_b;
    logic      sel_a;             // Lane A holds the reported branch

    assign advance = !stall_dcache && !stall_ex;
    // A branch held over a stall acts only in its first cycle
    assign br_ok   = !stall_dcache_buf && !stall_ex_buf && !flush_csr_buf;

    assign mem_br      = (mem_br_a || mem_br_b) && br_ok;
    assign mem_pc_br   = mem_br_a ? mem_pc_br_a : mem_pc_br_b;    // Lane A first
    assign mem_rf_we_b = mem_rf_we_b_ori && !mem_br_a;

    assign sel_a         = |mem_pd_type_a;
    assign mem_pd_type   = (sel_a ? mem_pd_type_a : mem_pd_type_b) & {pd_type_w{br_ok}};
    assign mem_pc_of_br  = sel_a ? mem_pc_a : mem_pc_b;
    assign mem_br_target = sel_a ? mem_pc_br_a_ori : mem_pc_br_b_ori;
    assign mem_br_jump   = sel_a ? mem_br_a_ori : mem_br_b_ori;

    // EX to MEM control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_rf_we_a     <= 1'b0;
            mem_rf_we_b_ori <= 1'b0;
            mem_br_a        <= 1'b0;
            mem_br_b        <= 1'b0;
            mem_pd_type_a   <= '0;
            mem_pd_type_b   <= '0;
        end else if (wb_flush_csr || (mem_br && advance)) begin
            mem_rf_we_a     <= 1'b0;    // Younger EX pair dropped
            mem_rf_we_b_ori <= 1'b0;
            mem_br_a        <= 1'b0;
            mem_br_b        <= 1'b0;
            mem_pd_type_a   <= '0;
            mem_pd_type_b   <= '0;
        end else if (mem_br) begin
            // Stalled: redirect is out, pair stays but loses its branch
            mem_rf_we_b_ori <= mem_rf_we_b;
            mem_br_a        <= 1'b0;
            mem_br_b        <= 1'b0;
            mem_pd_type_a   <= '0;
            mem_pd_type_b   <= '0;
        end else if (advance) begin
            mem_rf_we_a     <= ex_rf_we_a;
            mem_rf_we_b_ori <= ex_rf_we_b;
            mem_br_a        <= ex_br_a;
            mem_br_b        <= ex_br_b;
            mem_pd_type_a   <= ex_pd_type_a;
            mem_pd_type_b   <= ex_pd_type_b;
        end
    end

    // MEM to WB control, exceptions drop the write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rf_we_a <= 1'b0;
            wb_rf_we_b <= 1'b0;
        end else if (wb_flush_csr) begin
            wb_rf_we_a <= 1'b0;
            wb_rf_we_b <= 1'b0;
        end else if (advance) begin
            wb_rf_we_a <= mem_rf_we_a && !(|mem_ecode_a);
            wb_rf_we_b <= mem_rf_we_b && !(|mem_ecode_a) && !(|mem_ecode_b);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flush_csr_buf <= 1'b0;
        end else begin
            flush_csr_buf <= wb_flush_csr;
        end
    end

    // Payload of both stages
    always_ff @(posedge clk) begin
        if (advance) begin
            mem_pc_a         <= ex_pc_a;
            mem_pc_b         <= ex_pc_b;
            mem_pc_br_a      <= ex_pc_br_a;
            mem_pc_br_b      <= ex_pc_br_b;
            mem_br_a_ori     <= ex_br_a_ori;
            mem_br_b_ori     <= ex_br_b_ori;
            mem_pc_br_a_ori  <= ex_pc_br_a_ori;
            mem_pc_br_b_ori  <= ex_pc_br_b_ori;
            mem_alu_result_a <= ex_alu_result_a;
            mem_alu_result_b <= ex_alu_result_b;
            mem_rf_waddr_a   <= ex_rf_waddr_a;
            mem_rf_waddr_b   <= ex_rf_waddr_b;
            mem_wb_sel_b     <= ex_wb_sel_b;
            mem_mul_tmp1     <= ex_mul_tmp1;
            mem_mul_tmp2     <= ex_mul_tmp2;
            wb_rf_waddr_a    <= mem_rf_waddr_a;
            wb_rf_waddr_b    <= mem_rf_waddr_b;
            wb_rf_wdata_a    <= mem_rf_wdata_a;
            wb_rf_wdata_b    <= mem_rf_wdata_b;
        end
    end

    // CSR flush must hold off any redirect in the following cycle
    a_no_br_after_flush: assert property (
        @(posedge clk) disable iff (!arst_n) wb_flush_csr |=> !mem_br
    );

endmodule

/* src/backend_top.sv */
`timescale 1ns/100ps

module backend_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  backend_pkg::word_t     ex_pc_a,
    input  backend_pkg::word_t     ex_pc_b,
    input  backend_pkg::word_t     ex_alu_result_a,
    input  backend_pkg::word_t     ex_alu_result_b,
    input  logic                   ex_rf_we_a,
    input  logic                   ex_rf_we_b,
    input  backend_pkg::reg_addr_t ex_rf_waddr_a,
    input  backend_pkg::reg_addr_t ex_rf_waddr_b,
    input  backend_pkg::wb_sel_t   ex_wb_sel_b,
    input  logic                   ex_br_a,
    input  logic                   ex_br_b,
    input  backend_pkg::word_t     ex_pc_br_a,
    input  backend_pkg::word_t     ex_pc_br_b,
    input  logic                   ex_br_a_ori,
    input  logic                   ex_br_b_ori,
    input  backend_pkg::word_t     ex_pc_br_a_ori,
    input  backend_pkg::word_t     ex_pc_br_b_ori,
    input  backend_pkg::pd_type_t  ex_pd_type_a,
    input  backend_pkg::pd_type_t  ex_pd_type_b,
    input  backend_pkg::dword_t    ex_mul_tmp1,
    input  backend_pkg::dword_t    ex_mul_tmp2,
    input  backend_pkg::ecode_t    mem_ecode_a,
    input  backend_pkg::ecode_t    mem_ecode_b,
    input  logic                   wb_flush_csr,
    input  logic                   dcache_miss,
    input  logic                   div_busy,
    input  backend_pkg::reg_addr_t rf_raddr_0,
    input  backend_pkg::reg_addr_t rf_raddr_1,
    input  backend_pkg::word_t     bht_lookup_pc,
    output backend_pkg::word_t     rf_rdata_0,
    output backend_pkg::word_t     rf_rdata_1,
    output logic                   mem_br,
    output backend_pkg::word_t     mem_pc_br,
    output logic                   bht_hit,
    output backend_pkg::pd_type_t  bht_pd_type,
    output backend_pkg::word_t     bht_target,
    output logic                   bht_taken
);
    import backend_pkg::*;

    logic      stall_dcache;
    logic      stall_ex;
    logic      stall_dcache_buf;
    logic      stall_ex_buf;
    word_t     mem_alu_result_a;
    word_t     mem_alu_result_b;
    wb_sel_t   mem_wb_sel_b;
    dword_t    mem_mul_tmp1;
    dword_t    mem_mul_tmp2;
    word_t     mem_rf_wdata_a;
    word_t     mem_rf_wdata_b;
    pd_type_t  mem_pd_type;     // Branch resolved in MEM
    word_t     mem_pc_of_br;
    word_t     mem_br_target;
    logic      mem_br_jump;
    logic      wb_rf_we_a;
    logic      wb_rf_we_b;
    reg_addr_t wb_rf_waddr_a;
    reg_addr_t wb_rf_waddr_b;
    word_t     wb_rf_wdata_a;
    word_t     wb_rf_wdata_b;

    hazard_unit hazard_unit_i (
        .clk, .arst_n, .dcache_miss, .div_busy,
        .stall_dcache, .stall_ex, .stall_dcache_buf, .stall_ex_buf
    );

    ex_mem_wb_regs ex_mem_wb_regs_i (
        .clk, .arst_n,
        .stall_ex, .stall_ex_buf, .stall_dcache, .stall_dcache_buf,
        .wb_flush_csr, .mem_ecode_a, .mem_ecode_b,
        .ex_pc_a, .ex_pc_b, .ex_alu_result_a, .ex_alu_result_b,
        .ex_rf_we_a, .ex_rf_we_b, .ex_rf_waddr_a, .ex_rf_waddr_b, .ex_wb_sel_b,
        .ex_br_a, .ex_br_b, .ex_pc_br_a, .ex_pc_br_b,
        .ex_br_a_ori, .ex_br_b_ori, .ex_pc_br_a_ori, .ex_pc_br_b_ori,
        .ex_pd_type_a, .ex_pd_type_b, .ex_mul_tmp1, .ex_mul_tmp2,
        .mem_alu_result_a, .mem_alu_result_b, .mem_wb_sel_b,
        .mem_mul_tmp1, .mem_mul_tmp2, .mem_rf_wdata_a, .mem_rf_wdata_b,
        .mem_br, .mem_pc_br,
        .mem_pd_type, .mem_pc_of_br, .mem_br_target, .mem_br_jump,
        .wb_rf_we_a, .wb_rf_we_b, .wb_rf_waddr_a, .wb_rf_waddr_b,
        .wb_rf_wdata_a, .wb_rf_wdata_b
    );

    mem_result_select mem_result_select_i (
        .mem_alu_result_a, .mem_alu_result_b, .mem_wb_sel_b,
        .mem_mul_tmp1, .mem_mul_tmp2, .mem_rf_wdata_a, .mem_rf_wdata_b
    );

    regfile regfile_i (
        .clk, .arst_n,
        .we_a    (wb_rf_we_a),
        .waddr_a (wb_rf_waddr_a),
        .wdata_a (wb_rf_wdata_a),
        .we_b    (wb_rf_we_b),
        .waddr_b (wb_rf_waddr_b),
        .wdata_b (wb_rf_wdata_b),
        .raddr_0 (rf_raddr_0),
        .raddr_1 (rf_raddr_1),
        .rdata_0 (rf_rdata_0),
        .rdata_1 (rf_rdata_1)
    );

    branch_hist_table branch_hist_table_i (
        .clk, .arst_n,
        .upd_pd_type (mem_pd_type),
        .upd_pc      (mem_pc_of_br),
        .upd_target  (mem_br_target),
        .upd_taken   (mem_br_jump),
        .lookup_pc   (bht_lookup_pc),
        .hit         (bht_hit),
        .hit_pd_type (bht_pd_type),
        .hit_target  (bht_target),
        .hit_taken   (bht_taken)
    );

endmodule

/* verification/backend_tb.sv */
`timescale 1ns/100ps

module backend_tb;
    import backend_pkg::*;

    localparam int timeout_cycles = 400;    // Tests need about 50 cycles
    localparam int stall_cycles   = 3;

    logic      clk;
    logic      arst_n;
    word_t     ex_pc_a, ex_pc_b;
    word_t     ex_alu_result_a, ex_alu_result_b;
    logic      ex_rf_we_a, ex_rf_we_b;
    reg_addr_t ex_rf_waddr_a, ex_rf_waddr_b;
    wb_sel_t   ex_wb_sel_b;
    logic      ex_br_a, ex_br_b;
    word_t     ex_pc_br_a, ex_pc_br_b;
    logic      ex_br_a_ori, ex_br_b_ori;
    word_t     ex_pc_br_a_ori, ex_pc_br_b_ori;
    pd_type_t  ex_pd_type_a, ex_pd_type_b;
    dword_t    ex_mul_tmp1, ex_mul_tmp2;
    ecode_t    mem_ecode_a, mem_ecode_b;
    logic      wb_flush_csr;
    logic      dcache_miss;
    logic      div_busy;
    reg_addr_t rf_raddr_0, rf_raddr_1;
    word_t     bht_lookup_pc;
    word_t     rf_rdata_0, rf_rdata_1;
    logic      mem_br;
    word_t     mem_pc_br;
    logic      bht_hit;
    pd_type_t  bht_pd_type;
    word_t     bht_target;
    logic      bht_taken;

    int        err_cnt;
    int        cycle_cnt;

    backend_top backend_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: tests did not finish within %0d cycles", timeout_cycles);
            $display("sim failed");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            err_cnt++;
            $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;    // Drive point
    endtask

    task automatic clear_ex();
        ex_pc_a         = '0;
        ex_pc_b         = '0;
        ex_alu_result_a = '0;
        ex_alu_result_b = '0;
        ex_rf_we_a      = 1'b0;
        ex_rf_we_b      = 1'b0;
        ex_rf_waddr_a   = '0;
        ex_rf_waddr_b   = '0;
        ex_wb_sel_b     = 9'b000000001;    // ALU
        ex_br_a         = 1'b0;
        ex_br_b         = 1'b0;
        ex_pc_br_a      = '0;
        ex_pc_br_b      = '0;
        ex_br_a_ori     = 1'b0;
        ex_br_b_ori     = 1'b0;
        ex_pc_br_a_ori  = '0;
        ex_pc_br_b_ori  = '0;
        ex_pd_type_a    = '0;
        ex_pd_type_b    = '0;
        ex_mul_tmp1     = '0;
        ex_mul_tmp2     = '0;
    endtask

    task automatic issue_writes(input logic we_a, input reg_addr_t addr_a, input word_t data_a,
                                input logic we_b, input reg_addr_t addr_b, input word_t data_b);
        clear_ex();
        ex_rf_we_a      = we_a;
        ex_rf_waddr_a   = addr_a;
        ex_alu_result_a = data_a;
        ex_rf_we_b      = we_b;
        ex_rf_waddr_b   = addr_b;
        ex_alu_result_b = data_b;
    endtask

    task automatic expect_reg(input string name, input reg_addr_t addr, input word_t expected);
        rf_raddr_0 = addr;
        #1;
        check(name, expected, rf_rdata_0);
    endtask

    task automatic lookup(input word_t pc);
        bht_lookup_pc = pc;
        #1;
    endtask

    task automatic dual_write();
        word_t da;
        word_t db;
        word_t dc;
        da = $urandom;
        db = $urandom;
        dc = $urandom;
        rf_raddr_0 = 5'd5;
        rf_raddr_1 = 5'd6;
        issue_writes(1'b1, 5'd5, da, 1'b1, 5'd6, db);
        step();
        issue_writes(1'b1, 5'd7, db, 1'b1, 5'd7, dc);    // Same address
        step();
        clear_ex();
        check("dual_write early", 0, rf_rdata_0);
        step();
        check("dual_write port 0", da, rf_rdata_0);
        check("dual_write port 1", db, rf_rdata_1);
        step();
        rf_raddr_1 = 5'd7;
        expect_reg("dual_write same addr", 5'd7, dc);
        check("dual_write same addr port 1", dc, rf_rdata_1);
    endtask

    task automatic mul_select();
        dword_t t1;
        dword_t t2;
        dword_t sum;
        t1  = {$urandom, $urandom};
        t2  = {$urandom, $urandom};
        sum = t1 + t2;
        issue_writes(1'b0, 5'd0, '0, 1'b1, 5'd8, $urandom);
        ex_wb_sel_b = 9'b000000010;    // Low word
        ex_mul_tmp1 = t1;
        ex_mul_tmp2 = t2;
        step();
        ex_rf_waddr_b   = 5'd9;
        ex_alu_result_b = $urandom;
        ex_wb_sel_b     = 9'b000000100;    // High word
        step();
        clear_ex();
        step();
        expect_reg("mul_select low", 5'd8, sum[31:0]);
        step();
        expect_reg("mul_select high", 5'd9, sum[63:32]);
    endtask

    task automatic redirect();
        word_t da;
        word_t target;
        da     = $urandom;
        target = $urandom & 32'hffff_fffc;
        issue_writes(1'b1, 5'd10, da, 1'b1, 5'd11, $urandom);
        ex_br_a    = 1'b1;
        ex_pc_br_a = target;
        check("redirect idle", 0, mem_br);
        step();
        check("redirect mem_br", 1, mem_br);
        check("redirect pc", target, mem_pc_br);
        issue_writes(1'b1, 5'd12, $urandom, 1'b1, 5'd13, $urandom);    // Younger pair
        step();
        clear_ex();
        check("redirect single cycle", 0, mem_br);
        step();
        expect_reg("redirect lane a kept", 5'd10, da);
        expect_reg("redirect lane b lost", 5'd11, 0);
        step();
        expect_reg("redirect younger a lost", 5'd12, 0);
        expect_reg("redirect younger b lost", 5'd13, 0);
    endtask

    task automatic exception_and_flush();
        word_t da;
        da = $urandom;
        issue_writes(1'b1, 5'd14, $urandom, 1'b1, 5'd15, $urandom);
        step();
        clear_ex();
        mem_ecode_a = 7'h05;    // Pair sits in MEM
        step();
        mem_ecode_a = '0;
        issue_writes(1'b1, 5'd16, da, 1'b1, 5'd17, $urandom);
        step();
        clear_ex();
        mem_ecode_b = 7'h0d;
        expect_reg("ecode_a drops a", 5'd14, 0);
        expect_reg("ecode_a drops b", 5'd15, 0);
        step();
        mem_ecode_b = '0;
        step();
        expect_reg("ecode_b keeps a", 5'd16, da);
        expect_reg("ecode_b drops b", 5'd17, 0);
        issue_writes(1'b1, 5'd18, $urandom, 1'b1, 5'd19, $urandom);
        step();
        issue_writes(1'b1, 5'd20, $urandom, 1'b1, 5'd21, $urandom);
        ex_br_a      = 1'b1;
        ex_pc_br_a   = 32'h0000_2000;
        wb_flush_csr = 1'b1;
        step();
        wb_flush_csr = 1'b0;
        clear_ex();
        check("flush blocks mem_br", 0, mem_br);
        step();
        expect_reg("flush drops mem a", 5'd18, 0);
        expect_reg("flush drops mem b", 5'd19, 0);
        step();
        expect_reg("flush drops ex a", 5'd20, 0);
        expect_reg("flush drops ex b", 5'd21, 0);
    endtask

    task automatic stall_delay();
        word_t da;
        word_t target;
        int    br_cnt;
        int    i;
        da     = $urandom;
        target = $urandom & 32'hffff_fffc;
        issue_writes(1'b1, 5'd22, da, 1'b0, 5'd0, '0);
        step();
        clear_ex();
        dcache_miss = 1'b1;
        repeat (stall_cycles) step();
        dcache_miss = 1'b0;
        step();
        expect_reg("stall write not early", 5'd22, 0);
        step();
        expect_reg("stall write delayed", 5'd22, da);
        clear_ex();
        ex_br_a    = 1'b1;
        ex_pc_br_a = target;
        br_cnt     = 0;
        for (i = 0; i < stall_cycles + 3; i++) begin
            step();
            br_cnt += mem_br;
            if (i == 0) begin
                check("stall branch pc", target, mem_pc_br);
                clear_ex();
                dcache_miss = 1'b1;    // Branch held in MEM
            end else if (i == stall_cycles) begin
                dcache_miss = 1'b0;
            end
        end
        check("stall branch once", 1, br_cnt);
    endtask

    task automatic history_table();
        clear_ex();
        ex_pc_a        = 32'h2000_0010;
        ex_pc_b        = 32'h2000_0014;
        ex_pd_type_b   = 2'd2;    // Call in lane B only
        ex_br_b_ori    = 1'b1;
        ex_pc_br_b_ori = 32'h3000_0100;
        step();
        clear_ex();
        step();
        lookup(32'h2000_0014);
        check("bht lane b hit", 1, bht_hit);
        check("bht lane b type", 2, bht_pd_type);
        check("bht lane b target", 32'h3000_0100, bht_target);
        check("bht lane b taken", 1, bht_taken);
        lookup(32'h2000_0010);
        check("bht lane a miss", 0, bht_hit);
        ex_pc_a        = 32'h4000_0020;
        ex_pd_type_a   = 2'd1;
        ex_br_a_ori    = 1'b0;
        ex_pc_br_a_ori = 32'h4000_0080;
        ex_pc_b        = 32'h4000_0024;
        ex_pd_type_b   = 2'd3;
        ex_br_b_ori    = 1'b1;
        ex_pc_br_b_ori = 32'h4000_0200;
        step();
        clear_ex();
        step();
        lookup(32'h4000_0020);
        check("bht lane a hit", 1, bht_hit);
        check("bht lane a type", 1, bht_pd_type);
        check("bht lane a target", 32'h4000_0080, bht_target);
        check("bht lane a taken", 0, bht_taken);
        lookup(32'h4000_0024);
        check("bht lane b not written", 0, bht_hit);
        lookup(32'h5000_0020);
        check("bht tag mismatch", 0, bht_hit);
    endtask

    initial begin
        void'($urandom(18));
        err_cnt       = 0;
        cycle_cnt     = 0;
        arst_n        = 1'b0;
        clear_ex();
        mem_ecode_a   = '0;
        mem_ecode_b   = '0;
        wb_flush_csr  = 1'b0;
        dcache_miss   = 1'b0;
        div_busy      = 1'b0;
        rf_raddr_0    = '0;
        rf_raddr_1    = '0;
        bht_lookup_pc = '0;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        step();
        dual_write();
        mul_select();
        redirect();
        exception_and_flush();
        stall_delay();
        history_table();
        step();
        if (err_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1);
        end
    end

endmodule

/* verilog.f */
common/backend_pkg.sv
src/hazard_unit.sv
src/mem_result_select.sv
src/regfile.sv
src/branch_hist_table.sv
pipe_regs/ex_mem_wb_regs.sv
src/backend_top.sv
verification/backend_tb.sv

/* Bender.yml */
package:
  name: backend

sources:
  - common/backend_pkg.sv
  - src/hazard_unit.sv
  - src/mem_result_select.sv
  - src/regfile.sv
  - src/branch_hist_table.sv
  - pipe_regs/ex_mem_wb_regs.sv
  - src/backend_top.sv
  - target: simulation
    files:
      - verification/backend_tb.sv
